// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vend_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/credit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_unit (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire vend_ctrl_pkg::coin_t      coin,
    input  wire logic                      refund,
    input  wire logic                      charge_en,
    input  wire vend_catalog_pkg::credit_t charge_amt,
    output vend_catalog_pkg::credit_t      credit,
    output logic                           refunding,
    output logic                           change_pulse
);

    vend_catalog_pkg::credit_t coin_units;
    vend_catalog_pkg::credit_t after_charge;
    logic                      coin_ok;

    always_comb begin
        case (coin)
            vend_ctrl_pkg::coin_100:  coin_units = vend_catalog_pkg::coin_100_units;
            vend_ctrl_pkg::coin_500:  coin_units = vend_catalog_pkg::coin_500_units;
            vend_ctrl_pkg::coin_1000: coin_units = vend_catalog_pkg::coin_1000_units;
            default:                  coin_units = '0;
        endcase
    end

    assign after_charge = charge_en ? credit - charge_amt : credit;

    // 99 + 10 still fits in 7 bits
    assign coin_ok = !refunding && (coin_units != '0)
                     && ((after_charge + coin_units) <= vend_catalog_pkg::credit_max);

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit       <= '0;
            refunding    <= 1'b0;
            change_pulse <= 1'b0;
        end else begin
            change_pulse <= 1'b0;
            if (refunding) begin
                // pay back one unit per clock
                if (credit != '0) begin
                    credit       <= credit - 7'd1;
                    change_pulse <= 1'b1;
                end else begin
                    refunding <= 1'b0;
                end
            end else begin
                credit <= coin_ok ? after_charge + coin_units : after_charge;
                if (refund) begin
                    refunding <= 1'b1;
                end
            end
        end
    end

    credit_ceiling: assert property (@(posedge clk) disable iff (!rst)
        credit <= vend_catalog_pkg::credit_max);

endmodule

`default_nettype wire

// ==== design/restock_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module restock_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    admin_mode,
    input  wire logic                    restock,
    input  wire vend_catalog_pkg::item_t restock_item,
    stock_if.requester                   mem,
    output logic                         restock_done,
    output vend_catalog_pkg::stock_t     restock_level
);

    vend_ctrl_pkg::restock_state_t state;
    vend_catalog_pkg::item_t       item;
    logic                          has_room;

    assign has_room = (mem.rdata < vend_catalog_pkg::stock_limit);

    assign mem.req   = (state == vend_ctrl_pkg::r_read) || (state == vend_ctrl_pkg::r_write);
    assign mem.lock  = (state != vend_ctrl_pkg::r_idle);
    assign mem.we    = (state == vend_ctrl_pkg::r_write);
    assign mem.idx   = item;
    assign mem.wdata = restock_level;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= vend_ctrl_pkg::r_idle;
            restock_done <= 1'b0;
        end else begin
            restock_done <= 1'b0;
            case (state)
                vend_ctrl_pkg::r_idle: begin
                    if (restock && admin_mode) begin
                        state <= vend_ctrl_pkg::r_read;
                    end
                end
                vend_ctrl_pkg::r_read: begin
                    if (mem.gnt) begin
                        state <= vend_ctrl_pkg::r_wait;
                    end
                end
                vend_ctrl_pkg::r_wait: begin
                    if (mem.rvalid) begin
                        if (has_room) begin
                            state <= vend_ctrl_pkg::r_write;
                        end else begin
                            // shelf full, nothing to write
                            restock_done <= 1'b1;
                            state        <= vend_ctrl_pkg::r_idle;
                        end
                    end
                end
                vend_ctrl_pkg::r_write: begin
                    if (mem.gnt) begin
                        restock_done <= 1'b1;
                        state        <= vend_ctrl_pkg::r_idle;
                    end
                end
                default: state <= vend_ctrl_pkg::r_idle;
            endcase
        end
    end

    // product and resulting level
    always_ff @(posedge clk) begin
        if ((state == vend_ctrl_pkg::r_idle) && restock) begin
            item <= restock_item;
        end
        if ((state == vend_ctrl_pkg::r_wait) && mem.rvalid) begin
            restock_level <= has_room ? mem.rdata + 4'd1 : mem.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== design/sale_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sale_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      buy,
    input  wire vend_catalog_pkg::item_t   buy_item,
    input  wire vend_catalog_pkg::credit_t credit,
    input  wire logic                      refunding,
    stock_if.requester                     mem,
    output logic                           charge_en,
    output vend_catalog_pkg::credit_t      charge_amt,
    output logic                           sale_busy,
    output logic                           sale_done,
    output vend_ctrl_pkg::sale_status_t    sale_status,
    output logic                           dispense,
    output vend_catalog_pkg::item_t        dispense_item
);

    vend_ctrl_pkg::sale_state_t state;
    vend_catalog_pkg::item_t    item;
    vend_catalog_pkg::stock_t   count;
    logic                       can_pay;

    assign charge_amt = vend_catalog_pkg::price[item];

    // credit being refunded is not spendable
    assign can_pay = !refunding && (credit >= charge_amt);

    // charge as soon as the stock read says yes
    assign charge_en = (state == vend_ctrl_pkg::s_wait) && mem.rvalid
                       && (mem.rdata != '0) && can_pay;

    //////////////////////////////
    // stock table requests
    assign mem.req   = (state == vend_ctrl_pkg::s_read) || (state == vend_ctrl_pkg::s_write);
    assign mem.lock  = (state != vend_ctrl_pkg::s_idle);
    assign mem.we    = (state == vend_ctrl_pkg::s_write);
    assign mem.idx   = item;
    assign mem.wdata = count - 4'd1;

    assign sale_busy     = (state != vend_ctrl_pkg::s_idle);
    assign dispense_item = item;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= vend_ctrl_pkg::s_idle;
            sale_done <= 1'b0;
            dispense  <= 1'b0;
        end else begin
            sale_done <= 1'b0;
            dispense  <= 1'b0;
            case (state)
                vend_ctrl_pkg::s_idle: begin
                    if (buy && !refunding) begin
                        state <= vend_ctrl_pkg::s_read;
                    end
                end
                vend_ctrl_pkg::s_read: begin
                    if (mem.gnt) begin
                        state <= vend_ctrl_pkg::s_wait;
                    end
                end
                vend_ctrl_pkg::s_wait: begin
                    if (mem.rvalid) begin
                        if (charge_en) begin
                            state <= vend_ctrl_pkg::s_write;
                        end else begin
                            // refused, lock drops with the return to idle
                            sale_done <= 1'b1;
                            state     <= vend_ctrl_pkg::s_idle;
                        end
                    end
                end
                vend_ctrl_pkg::s_write: begin
                    if (mem.gnt) begin
                        sale_done <= 1'b1;
                        dispense  <= 1'b1;
                        state     <= vend_ctrl_pkg::s_idle;
                    end
                end
                default: state <= vend_ctrl_pkg::s_idle;
            endcase
        end
    end

    // latched product, stock and result
    always_ff @(posedge clk) begin
        if ((state == vend_ctrl_pkg::s_idle) && buy) begin
            item <= buy_item;
        end
        if ((state == vend_ctrl_pkg::s_wait) && mem.rvalid) begin
            count <= mem.rdata;
            // sold out wins over missing money
            if (mem.rdata == '0) begin
                sale_status <= vend_ctrl_pkg::sale_sold_out;
            end else if (!can_pay) begin
                sale_status <= vend_ctrl_pkg::sale_no_money;
            end else begin
                sale_status <= vend_ctrl_pkg::sale_ok;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stock_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module stock_arbiter (
    input wire logic      clk,
    input wire logic      rst,
    stock_if.arbiter_side sale,
    stock_if.arbiter_side rstk,
    stock_if.requester    mem
);

    // last granted requester, also the lock owner while locked
    logic last_rstk;
    logic locked;
    logic pick_rstk;

    always_comb begin
        if (locked) begin
            pick_rstk = last_rstk;
        end else if (sale.req && rstk.req) begin
            // round robin on contention
            pick_rstk = !last_rstk;
        end else begin
            pick_rstk = rstk.req;
        end
    end

    //////////////////////////////
    // forward the selected request
    assign mem.req   = pick_rstk ? rstk.req   : sale.req;
    assign mem.lock  = pick_rstk ? rstk.lock  : sale.lock;
    assign mem.we    = pick_rstk ? rstk.we    : sale.we;
    assign mem.idx   = pick_rstk ? rstk.idx   : sale.idx;
    assign mem.wdata = pick_rstk ? rstk.wdata : sale.wdata;

    assign sale.gnt = mem.gnt && !pick_rstk;
    assign rstk.gnt = mem.gnt && pick_rstk;

    // read return goes to whoever got the previous grant
    assign sale.rdata  = mem.rdata;
    assign rstk.rdata  = mem.rdata;
    assign sale.rvalid = mem.rvalid && !last_rstk;
    assign rstk.rvalid = mem.rvalid && last_rstk;

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_rstk <= 1'b0;
            locked    <= 1'b0;
        end else if (mem.gnt) begin
            last_rstk <= pick_rstk;
            // locked read opens the window, the write closes it
            locked    <= mem.lock && !mem.we;
        end else if (locked && !mem.lock) begin
            // owner gave up without writing
            locked <= 1'b0;
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst)
        !(sale.gnt && rstk.gnt));

endmodule

`default_nettype wire

// ==== design/stock_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface stock_if;

    // request side
    logic                     req;
    logic                     lock;
    logic                     we;
    vend_catalog_pkg::item_t  idx;
    vend_catalog_pkg::stock_t wdata;

    // grant and read return
    logic                     gnt;
    vend_catalog_pkg::stock_t rdata;
    logic                     rvalid;

    modport requester (output req, lock, we, idx, wdata, input gnt, rdata, rvalid);

    modport arbiter_side (input req, lock, we, idx, wdata, output gnt, rdata, rvalid);

    // the table has no use for the lock
    modport memory (input req, we, idx, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

// ==== design/stock_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module stock_table (
    input wire logic clk,
    input wire logic rst,
    stock_if.memory  mem
);

    vend_catalog_pkg::stock_t count [vend_catalog_pkg::num_products];

    // single port, always ready
    assign mem.gnt = mem.req;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < vend_catalog_pkg::num_products; i++) begin
                count[i] <= vend_catalog_pkg::init_stock[i];
            end
            mem.rvalid <= 1'b0;
        end else begin
            mem.rvalid <= mem.req && !mem.we;
            if (mem.req && mem.we) begin
                count[mem.idx] <= mem.wdata;
            end
        end
    end

    // read data one cycle after the grant
    always_ff @(posedge clk) begin
        if (mem.req && !mem.we) begin
            mem.rdata <= count[mem.idx];
        end
    end

    // controllers must never store more than the shelf holds
    write_in_range: assert property (@(posedge clk) disable iff (!rst)
        (mem.req && mem.we) |-> (mem.wdata <= vend_catalog_pkg::stock_limit));

endmodule

`default_nettype wire

// ==== design/vend_catalog_pkg.sv ====
`default_nettype none

package vend_catalog_pkg;

    localparam int num_products = 4;

    // product index and stock count
    typedef logic [1:0] item_t;
    typedef logic [3:0] stock_t;

    // credit counted in 100 won units
    typedef logic [6:0] credit_t;

    localparam stock_t  stock_limit = 4'd9;
    localparam credit_t credit_max  = 7'd99;

    //////////////////////////////
    // per product tables, product 0 sits in the low slot
    localparam credit_t [num_products-1:0] price = {7'd18, 7'd15, 7'd12, 7'd10};

    localparam stock_t [num_products-1:0] init_stock = {4'd4, 4'd0, 4'd1, 4'd9};

    //////////////////////////////
    // coin values in credit units
    localparam credit_t coin_100_units  = 7'd1;
    localparam credit_t coin_500_units  = 7'd5;
    localparam credit_t coin_1000_units = 7'd10;

endpackage

`default_nettype wire

// ==== design/vend_ctrl_pkg.sv ====
`default_nettype none

package vend_ctrl_pkg;

    // coin slot input, one kind per pulse
    typedef enum logic [1:0] {
        coin_none,
        coin_100,
        coin_500,
        coin_1000
    } coin_t;

    // sale result, valid with sale_done
    typedef enum logic [1:0] {
        sale_ok,
        sale_sold_out,
        sale_no_money
    } sale_status_t;

    //////////////////////////////
    // controller FSMs
    typedef enum logic [2:0] {
        s_idle,
        s_read,
        s_wait,
        s_write
    } sale_state_t;

    typedef enum logic [1:0] {
        r_idle,
        r_read,
        r_wait,
        r_write
    } restock_state_t;

endpackage

`default_nettype wire

// ==== design/vend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vend_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire vend_ctrl_pkg::coin_t        coin,
    input  wire logic                        buy,
    input  wire vend_catalog_pkg::item_t     buy_item,
    input  wire logic                        refund,
    input  wire logic                        admin_mode,
    input  wire logic                        restock,
    input  wire vend_catalog_pkg::item_t     restock_item,
    output wire vend_catalog_pkg::credit_t   credit,
    output wire logic                        change_pulse,
    output wire logic                        refunding,
    output wire logic                        sale_busy,
    output wire logic                        sale_done,
    output wire vend_ctrl_pkg::sale_status_t sale_status,
    output wire logic                        dispense,
    output wire vend_catalog_pkg::item_t     dispense_item,
    output wire logic                        restock_done,
    output wire vend_catalog_pkg::stock_t    restock_level
);

    wire logic                      charge_en;
    wire vend_catalog_pkg::credit_t charge_amt;

    // one bus per requester, one into the table
    stock_if sale_bus ();
    stock_if rstk_bus ();
    stock_if table_bus ();

    //////////////////////////////
    // money path
    credit_unit credit_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .coin         (coin),
        .refund       (refund),
        .charge_en    (charge_en),
        .charge_amt   (charge_amt),
        .credit       (credit),
        .refunding    (refunding),
        .change_pulse (change_pulse)
    );

    //////////////////////////////
    // controllers sharing the stock table
    sale_ctrl sale_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .buy           (buy),
        .buy_item      (buy_item),
        .credit        (credit),
        .refunding     (refunding),
        .mem           (sale_bus),
        .charge_en     (charge_en),
        .charge_amt    (charge_amt),
        .sale_busy     (sale_busy),
        .sale_done     (sale_done),
        .sale_status   (sale_status),
        .dispense      (dispense),
        .dispense_item (dispense_item)
    );

    restock_ctrl restock_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .admin_mode    (admin_mode),
        .restock       (restock),
        .restock_item  (restock_item),
        .mem           (rstk_bus),
        .restock_done  (restock_done),
        .restock_level (restock_level)
    );

    stock_arbiter stock_arbiter_inst (
        .clk  (clk),
        .rst  (rst),
        .sale (sale_bus),
        .rstk (rstk_bus),
        .mem  (table_bus)
    );

    stock_table stock_table_inst (
        .clk (clk),
        .rst (rst),
        .mem (table_bus)
    );

endmodule

`default_nettype wire

// ==== project.f ====
design/vend_catalog_pkg.sv
design/vend_ctrl_pkg.sv
design/stock_if.sv
design/stock_table.sv
design/stock_arbiter.sv
design/credit_unit.sv
design/sale_ctrl.sv
design/restock_ctrl.sv
design/vend_top.sv
tests/vend_tb.sv

// ==== tests/vend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vend_tb;

    localparam int timeout_cycles = 200;

    //////////////////////////////
    // table encodings
    localparam logic [3:0] c100    = 4'(vend_ctrl_pkg::coin_100);
    localparam logic [3:0] c500    = 4'(vend_ctrl_pkg::coin_500);
    localparam logic [3:0] c1000   = 4'(vend_ctrl_pkg::coin_1000);
    localparam logic [3:0] st_ok   = 4'(vend_ctrl_pkg::sale_ok);
    localparam logic [3:0] st_sold = 4'(vend_ctrl_pkg::sale_sold_out);
    localparam logic [3:0] st_poor = 4'(vend_ctrl_pkg::sale_no_money);
    localparam logic [3:0] nil     = 4'd0;

    typedef enum logic [2:0] {
        op_coin,
        op_fill,
        op_buy,
        op_restock,
        op_restock_off,
        op_refund
    } op_t;

    typedef struct packed {
        op_t        op;
        logic [3:0] arg;
        logic [6:0] credit;
        logic [3:0] result;
        logic [6:0] pulses;
    } row_t;

    // op, argument, credit after, status or level, pulse count
    localparam int num_rows = 23;
    localparam row_t rows [num_rows] = '{
        '{op_coin,        c500,  7'd5,  nil,     7'd0},
        '{op_coin,        c500,  7'd10, nil,     7'd0},
        '{op_coin,        c1000, 7'd20, nil,     7'd0},
        '{op_buy,         4'd0,  7'd10, st_ok,   7'd1},
        '{op_buy,         4'd3,  7'd10, st_poor, 7'd0},
        '{op_coin,        c1000, 7'd20, nil,     7'd0},
        '{op_buy,         4'd1,  7'd8,  st_ok,   7'd1},
        '{op_buy,         4'd1,  7'd8,  st_sold, 7'd0},
        '{op_buy,         4'd2,  7'd8,  st_sold, 7'd0},
        '{op_coin,        c1000, 7'd18, nil,     7'd0},
        '{op_buy,         4'd2,  7'd18, st_sold, 7'd0},
        '{op_restock_off, 4'd2,  7'd18, nil,     7'd0},
        '{op_restock,     4'd2,  7'd18, 4'd1,    7'd1},
        '{op_buy,         4'd2,  7'd3,  st_ok,   7'd1},
        '{op_restock,     4'd0,  7'd3,  4'd9,    7'd1},
        '{op_restock,     4'd0,  7'd3,  4'd9,    7'd1},
        '{op_coin,        c100,  7'd4,  nil,     7'd0},
        '{op_fill,        4'd9,  7'd94, nil,     7'd0},
        '{op_coin,        c1000, 7'd94, nil,     7'd0},
        '{op_coin,        c500,  7'd99, nil,     7'd0},
        '{op_coin,        c100,  7'd99, nil,     7'd0},
        '{op_refund,      4'd1,  7'd0,  nil,     7'd99},
        '{op_refund,      4'd0,  7'd0,  nil,     7'd0}
    };

    logic                        clk;
    logic                        rst;
    vend_ctrl_pkg::coin_t        coin;
    logic                        buy;
    vend_catalog_pkg::item_t     buy_item;
    logic                        refund;
    logic                        admin_mode;
    logic                        restock;
    vend_catalog_pkg::item_t     restock_item;
    wire vend_catalog_pkg::credit_t   credit;
    wire logic                        change_pulse;
    wire logic                        refunding;
    wire logic                        sale_busy;
    wire logic                        sale_done;
    wire vend_ctrl_pkg::sale_status_t sale_status;
    wire logic                        dispense;
    wire vend_catalog_pkg::item_t     dispense_item;
    wire logic                        restock_done;
    wire vend_catalog_pkg::stock_t    restock_level;

    vend_top vend_top_inst (
        .clk           (clk),
        .rst           (rst),
        .coin          (coin),
        .buy           (buy),
        .buy_item      (buy_item),
        .refund        (refund),
        .admin_mode    (admin_mode),
        .restock       (restock),
        .restock_item  (restock_item),
        .credit        (credit),
        .change_pulse  (change_pulse),
        .refunding     (refunding),
        .sale_busy     (sale_busy),
        .sale_done     (sale_done),
        .sale_status   (sale_status),
        .dispense      (dispense),
        .dispense_item (dispense_item),
        .restock_done  (restock_done),
        .restock_level (restock_level)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // checking
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", timeout_cycles, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    //////////////////////////////
    // stimulus, one pulse each
    task automatic insert_coin(input logic [3:0] kind);
        @(posedge clk);
        coin <= vend_ctrl_pkg::coin_t'(kind[1:0]);
        @(posedge clk);
        coin <= vend_ctrl_pkg::coin_none;
        @(negedge clk);
    endtask

    task automatic buy_product(input row_t row);
        int wait_cycles;
        @(posedge clk);
        buy      <= 1'b1;
        buy_item <= row.arg[1:0];
        @(posedge clk);
        buy <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        // an accepted buy keeps the controller occupied
        check_value("sale_busy", 32'(sale_busy), 32'd1);
        while (!sale_done) begin
            if (wait_cycles == timeout_cycles) begin
                stop_on_timeout("sale_done");
            end
            wait_cycles++;
            @(negedge clk);
        end
        check_value("sale_status", 32'(sale_status), 32'(row.result));
        check_value("dispense", 32'(dispense), 32'(row.pulses));
        if (dispense) begin
            check_value("dispense_item", 32'(dispense_item), 32'(row.arg));
        end
    endtask

    task automatic restock_product(input row_t row);
        int wait_cycles;
        @(posedge clk);
        admin_mode   <= 1'b1;
        restock      <= 1'b1;
        restock_item <= row.arg[1:0];
        @(posedge clk);
        restock <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!restock_done) begin
            if (wait_cycles == timeout_cycles) begin
                stop_on_timeout("restock_done");
            end
            wait_cycles++;
            @(negedge clk);
        end
        check_value("restock_level", 32'(restock_level), 32'(row.result));
        @(posedge clk);
        admin_mode <= 1'b0;
        @(negedge clk);
    endtask

    // no admin, so nothing may come back in the window
    task automatic watch_no_restock(input row_t row);
        int seen;
        seen = 0;
        @(posedge clk);
        restock      <= 1'b1;
        restock_item <= row.arg[1:0];
        @(posedge clk);
        restock <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (restock_done) begin
                seen++;
            end
        end
        check_value("restock_done count", 32'(seen), 32'(row.pulses));
    endtask

    task automatic refund_credit(input row_t row);
        int pulses;
        int wait_cycles;
        pulses = 0;
        wait_cycles = 0;
        @(posedge clk);
        refund <= 1'b1;
        @(posedge clk);
        refund <= 1'b0;
        // coin that lands while paying out
        if (row.arg != 4'd0) begin
            coin <= vend_ctrl_pkg::coin_1000;
        end
        @(posedge clk);
        coin <= vend_ctrl_pkg::coin_none;
        @(negedge clk);
        while (refunding) begin
            if (change_pulse) begin
                pulses++;
            end
            if (wait_cycles == timeout_cycles) begin
                stop_on_timeout("refunding to fall");
            end
            wait_cycles++;
            @(negedge clk);
        end
        check_value("change_pulse count", 32'(pulses), 32'(row.pulses));
    endtask

    task automatic run_row(input row_t row);
        case (row.op)
            op_coin: insert_coin(row.arg);
            op_fill: begin
                for (int i = 0; i < int'(row.arg); i++) begin
                    insert_coin(c1000);
                end
            end
            op_buy:         buy_product(row);
            op_restock:     restock_product(row);
            op_restock_off: watch_no_restock(row);
            default:        refund_credit(row);
        endcase
        check_value("credit", 32'(credit), 32'(row.credit));
    endtask

    initial begin
        rst          = 1'b0;
        coin         = vend_ctrl_pkg::coin_none;
        buy          = 1'b0;
        buy_item     = '0;
        refund       = 1'b0;
        admin_mode   = 1'b0;
        restock      = 1'b0;
        restock_item = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
